// File: logic/eth_rx_pkg.sv
package eth_rx_pkg;

   // One MII data nibble
   typedef logic [3:0] nibble_t;

   // One frame byte
   typedef logic [7:0] byte_t;

   // Frame length in bytes, FCS included, up to 2047
   typedef logic [10:0] byte_cnt_t;

   // Buffer word, first received byte in the low lane
   typedef logic [31:0] word_t;

   // CRC-32 register
   typedef logic [31:0] crc_t;

   // Station address, first wire byte in bits 47:40
   typedef logic [47:0] mac_addr_t;

   // Destination that every station accepts
   localparam mac_addr_t BROADCAST_MAC = 48'hFF_FF_FF_FF_FF_FF;

   // Register value after a good frame has passed with its FCS,
   // preset all ones and no final inversion
   localparam crc_t CRC_RESIDUE = 32'hC704_DD7B;

   // Start-of-frame delimiter nibble, ends the preamble
   localparam nibble_t SFD_NIBBLE = 4'hD;

   // Preamble nibble as seen on the MII data lines
   localparam nibble_t PRE_NIBBLE = 4'h5;

   // Destination address length in bytes
   localparam int ADDR_BYTES = 6;

endpackage

// File: logic/mii_nibble_assembler.sv
`timescale 1ns/100ps

module mii_nibble_assembler (
   input  logic                RX_CLK,
   input  logic                ETH_PHY_RESETN,
   input  eth_rx_pkg::nibble_t rx_data,
   input  logic                rx_dv,
   output logic                byte_valid,
   output eth_rx_pkg::byte_t   byte_data,
   output logic                frame_start,
   output logic                frame_end,
   output logic                frame_odd,
   output logic                phy_dv_detected
);
   import eth_rx_pkg::*;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_PREAMBLE,
      ST_DATA,
      ST_DISCARD
   } state_t;

   state_t  state;
   nibble_t data_q;
   nibble_t low_nibble;
   logic    dv_q;
   logic    have_low;
   logic    first_byte;

   // Input capture stage, the FSM works on the sampled MII lines
   always_ff @(posedge RX_CLK or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         dv_q <= 1'b0;
      end else begin
         dv_q <= rx_dv;
      end
   end

   always_ff @(posedge RX_CLK) begin
      data_q <= rx_data;
      if (state == ST_DATA && dv_q && !have_low) begin
         low_nibble <= data_q;
      end
      if (state == ST_DATA && dv_q && have_low) begin
         // Low nibble arrives first on the wire
         byte_data <= {data_q, low_nibble};
      end
   end

   always_ff @(posedge RX_CLK or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         state       <= ST_IDLE;
         have_low    <= 1'b0;
         first_byte  <= 1'b0;
         byte_valid  <= 1'b0;
         frame_start <= 1'b0;
         frame_end   <= 1'b0;
         frame_odd   <= 1'b0;
      end else begin
         byte_valid  <= 1'b0;
         frame_start <= 1'b0;
         frame_end   <= 1'b0;
         case (state)
            ST_IDLE: begin
               if (dv_q) begin
                  // Anything but preamble means we joined mid-frame
                  state <= (data_q == PRE_NIBBLE) ? ST_PREAMBLE : ST_DISCARD;
               end
            end
            ST_PREAMBLE: begin
               if (!dv_q) begin
                  state <= ST_IDLE;
               end else if (data_q == SFD_NIBBLE) begin
                  state      <= ST_DATA;
                  have_low   <= 1'b0;
                  first_byte <= 1'b1;
               end else if (data_q != PRE_NIBBLE) begin
                  state <= ST_DISCARD;
               end
            end
            ST_DATA: begin
               if (!dv_q) begin
                  state     <= ST_IDLE;
                  frame_end <= 1'b1;
                  frame_odd <= have_low;
               end else begin
                  have_low <= !have_low;
                  if (have_low) begin
                     byte_valid  <= 1'b1;
                     frame_start <= first_byte;
                     first_byte  <= 1'b0;
                  end
               end
            end
            default: begin
               if (!dv_q) begin
                  state <= ST_IDLE;
               end
            end
         endcase
      end
   end

   // Sticky PHY activity flag
   always_ff @(posedge RX_CLK or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         phy_dv_detected <= 1'b0;
      end else if (rx_dv) begin
         phy_dv_detected <= 1'b1;
      end
   end

endmodule

// File: logic/eth_addr_filter.sv
`timescale 1ns/100ps

module eth_addr_filter #(
   parameter eth_rx_pkg::mac_addr_t ETH_MAC_ADDR = 48'h02_00_00_00_00_01
) (
   input  logic              RX_CLK,
   input  logic              ETH_PHY_RESETN,
   input  logic              in_valid,
   input  eth_rx_pkg::byte_t in_data,
   input  logic              in_start,
   input  logic              in_end,
   input  logic              in_odd,
   output logic              out_valid,
   output eth_rx_pkg::byte_t out_data,
   output logic              out_start,
   output logic              out_end,
   output logic              out_odd,
   output logic              addr_match
);
   import eth_rx_pkg::*;

   logic [2:0] addr_cnt;
   logic [2:0] byte_idx;
   logic       uni_hit;
   logic       bcast_hit;
   logic       addr_phase;

   // Byte of an address in wire order, index 0 is the first byte sent
   function automatic byte_t addr_byte(mac_addr_t addr, logic [2:0] idx);
      case (idx)
         3'd0:    return addr[47:40];
         3'd1:    return addr[39:32];
         3'd2:    return addr[31:24];
         3'd3:    return addr[23:16];
         3'd4:    return addr[15:8];
         default: return addr[7:0];
      endcase
   endfunction

   assign byte_idx   = in_start ? 3'd0 : addr_cnt;
   assign addr_phase = in_valid && (in_start || addr_cnt < 3'(ADDR_BYTES));

   always_ff @(posedge RX_CLK or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         addr_cnt   <= '0;
         uni_hit    <= 1'b0;
         bcast_hit  <= 1'b0;
         addr_match <= 1'b0;
      end else begin
         if (addr_phase) begin
            addr_cnt  <= byte_idx + 3'd1;
            uni_hit   <= (in_start || uni_hit) &&
                         (in_data == addr_byte(ETH_MAC_ADDR, byte_idx));
            bcast_hit <= (in_start || bcast_hit) &&
                         (in_data == addr_byte(BROADCAST_MAC, byte_idx));
         end else if (in_end) begin
            // Next frame starts from scratch, a runt never matches
            addr_cnt <= '0;
         end
         addr_match <= (addr_cnt == 3'(ADDR_BYTES)) && (uni_hit || bcast_hit);
      end
   end

   always_ff @(posedge RX_CLK or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         out_valid <= 1'b0;
         out_start <= 1'b0;
         out_end   <= 1'b0;
         out_odd   <= 1'b0;
      end else begin
         out_valid <= in_valid;
         out_start <= in_start;
         out_end   <= in_end;
         out_odd   <= in_odd;
      end
   end

   always_ff @(posedge RX_CLK) begin
      out_data <= in_data;
   end

endmodule

// File: logic/eth_crc_check.sv
`timescale 1ns/100ps

module eth_crc_check (
   input  logic              RX_CLK,
   input  logic              ETH_PHY_RESETN,
   input  logic              in_valid,
   input  eth_rx_pkg::byte_t in_data,
   input  logic              in_start,
   input  logic              in_end,
   input  logic              in_odd,
   input  logic              in_match,
   output logic              out_valid,
   output eth_rx_pkg::byte_t out_data,
   output logic              out_start,
   output logic              out_end,
   output logic              out_odd,
   output logic              out_match,
   output logic              crc_ok,
   output eth_rx_pkg::crc_t  crc_value
);
   import eth_rx_pkg::*;

   // IEEE 802.3 generator, MSB-aligned register
   localparam crc_t CRC_POLY = 32'h04C1_1DB7;

   crc_t crc_q;
   crc_t crc_seed;

   // Fold one byte in, least significant bit first as sent on the wire
   function automatic crc_t crc_next(crc_t crc, byte_t data);
      crc_t c;
      logic fb;
      c = crc;
      for (int i = 0; i < 8; i++) begin
         fb = c[31] ^ data[i];
         c  = {c[30:0], 1'b0};
         if (fb) begin
            c = c ^ CRC_POLY;
         end
      end
      return c;
   endfunction

   // Preset to all ones on the first byte of a frame
   assign crc_seed = in_start ? 32'hFFFF_FFFF : crc_q;

   always_ff @(posedge RX_CLK or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         crc_q     <= 32'hFFFF_FFFF;
         crc_ok    <= 1'b0;
         crc_value <= '0;
      end else begin
         if (in_valid) begin
            crc_q <= crc_next(crc_seed, in_data);
         end
         if (in_end) begin
            // Last byte was folded in at least one cycle earlier
            crc_ok    <= (crc_q == CRC_RESIDUE);
            crc_value <= crc_q;
         end
      end
   end

   always_ff @(posedge RX_CLK or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         out_valid <= 1'b0;
         out_start <= 1'b0;
         out_end   <= 1'b0;
         out_odd   <= 1'b0;
         out_match <= 1'b0;
      end else begin
         out_valid <= in_valid;
         out_start <= in_start;
         out_end   <= in_end;
         out_odd   <= in_odd;
         out_match <= in_match;
      end
   end

   always_ff @(posedge RX_CLK) begin
      out_data <= in_data;
   end

endmodule

// File: logic/rx_frame_buffer.sv
`timescale 1ns/100ps

module rx_frame_buffer #(
   parameter int BUF_ADDR_W = 9
) (
   input  logic                  RX_CLK,
   input  logic                  ETH_PHY_RESETN,
   input  logic                  in_valid,
   input  eth_rx_pkg::byte_t     in_data,
   input  logic                  in_start,
   input  logic                  in_end,
   input  logic                  in_odd,
   input  logic                  in_match,
   input  logic                  crc_ok,
   input  logic                  rcv_ack,
   input  logic [BUF_ADDR_W-1:0] rd_addr,
   output eth_rx_pkg::word_t     rd_data,
   output logic                  data_rcvd,
   output eth_rx_pkg::byte_cnt_t rcv_size
);
   import eth_rx_pkg::*;

   localparam int BUF_BYTES = 4 * (2 ** BUF_ADDR_W);

   word_t           mem [2**BUF_ADDR_W];
   byte_cnt_t       byte_cnt;
   byte_cnt_t       wr_idx;
   logic [BUF_ADDR_W-1:0] wr_word;
   logic [3:0]      wr_strb;
   logic            wr_ok;
   logic            overflow;
   logic            accept;

   // Byte position of the incoming byte, restarts with each frame
   assign wr_idx  = in_start ? '0 : byte_cnt;
   assign wr_word = wr_idx[BUF_ADDR_W+1:2];
   assign wr_strb = 4'b0001 << wr_idx[1:0];

   // Room left in the buffer and in the length counter
   assign wr_ok = in_valid && (int'(wr_idx) < BUF_BYTES) && (wr_idx != '1);

   assign accept = in_end && !data_rcvd && in_match && crc_ok && !in_odd && !overflow;

   always_ff @(posedge RX_CLK or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         byte_cnt <= '0;
         overflow <= 1'b0;
      end else if (in_valid) begin
         byte_cnt <= wr_ok ? byte_cnt_t'(wr_idx + 1'b1) : wr_idx;
         overflow <= (overflow && !in_start) || !wr_ok;
      end
   end

   // Received flag and length, frozen until the host acknowledges
   always_ff @(posedge RX_CLK or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         data_rcvd <= 1'b0;
         rcv_size  <= '0;
      end else if (rcv_ack) begin
         data_rcvd <= 1'b0;
      end else if (accept) begin
         data_rcvd <= 1'b1;
         rcv_size  <= byte_cnt;
      end
   end

   // Lane write, held off while a frame waits for the host
   always_ff @(posedge RX_CLK) begin
      if (wr_ok && !data_rcvd) begin
         for (int lane = 0; lane < 4; lane++) begin
            if (wr_strb[lane]) begin
               mem[wr_word][8*lane +: 8] <= in_data;
            end
         end
      end
      rd_data <= mem[rd_addr];
   end

endmodule

// File: logic/eth_rx_top.sv
`timescale 1ns/100ps

module eth_rx_top #(
   parameter eth_rx_pkg::mac_addr_t ETH_MAC_ADDR = 48'h02_00_00_00_00_01,
   parameter int                    BUF_ADDR_W   = 9
) (
   input  logic                  RX_CLK,
   input  logic                  ETH_PHY_RESETN,
   input  eth_rx_pkg::nibble_t   RX_DATA,
   input  logic                  RX_DV,
   input  logic                  rcv_ack,
   input  logic [BUF_ADDR_W-1:0] rd_addr,
   output eth_rx_pkg::word_t     rd_data,
   output logic                  data_rcvd,
   output eth_rx_pkg::byte_cnt_t rcv_size,
   output eth_rx_pkg::crc_t      crc_value,
   output logic                  phy_dv_detected
);
   import eth_rx_pkg::*;

   // Assembler to filter
   logic  asm_valid, asm_start, asm_end, asm_odd;
   byte_t asm_data;

   // Filter to CRC check
   logic  flt_valid, flt_start, flt_end, flt_odd, flt_match;
   byte_t flt_data;

   // CRC check to buffer
   logic  crc_valid, crc_start, crc_end, crc_odd, crc_match, crc_good;
   byte_t crc_data;

   mii_nibble_assembler u_assembler (
      .RX_CLK          (RX_CLK),
      .ETH_PHY_RESETN  (ETH_PHY_RESETN),
      .rx_data         (RX_DATA),
      .rx_dv           (RX_DV),
      .byte_valid      (asm_valid),
      .byte_data       (asm_data),
      .frame_start     (asm_start),
      .frame_end       (asm_end),
      .frame_odd       (asm_odd),
      .phy_dv_detected (phy_dv_detected)
   );

   eth_addr_filter #(.ETH_MAC_ADDR(ETH_MAC_ADDR)) u_filter (
      .RX_CLK (RX_CLK), .ETH_PHY_RESETN (ETH_PHY_RESETN),
      .in_valid (asm_valid), .in_data (asm_data), .in_start (asm_start),
      .in_end (asm_end), .in_odd (asm_odd),
      .out_valid (flt_valid), .out_data (flt_data), .out_start (flt_start),
      .out_end (flt_end), .out_odd (flt_odd), .addr_match (flt_match)
   );

   eth_crc_check u_crc (
      .RX_CLK (RX_CLK), .ETH_PHY_RESETN (ETH_PHY_RESETN),
      .in_valid (flt_valid), .in_data (flt_data), .in_start (flt_start),
      .in_end (flt_end), .in_odd (flt_odd), .in_match (flt_match),
      .out_valid (crc_valid), .out_data (crc_data), .out_start (crc_start),
      .out_end (crc_end), .out_odd (crc_odd), .out_match (crc_match),
      .crc_ok (crc_good), .crc_value (crc_value)
   );

   rx_frame_buffer #(.BUF_ADDR_W(BUF_ADDR_W)) u_buffer (
      .RX_CLK (RX_CLK), .ETH_PHY_RESETN (ETH_PHY_RESETN),
      .in_valid (crc_valid), .in_data (crc_data), .in_start (crc_start),
      .in_end (crc_end), .in_odd (crc_odd), .in_match (crc_match),
      .crc_ok (crc_good), .rcv_ack (rcv_ack), .rd_addr (rd_addr),
      .rd_data (rd_data), .data_rcvd (data_rcvd), .rcv_size (rcv_size)
   );

endmodule

// File: dv/eth_rx_chk.sv
`timescale 1ns/100ps

module eth_rx_chk (
   input logic                  RX_CLK,
   input logic                  ETH_PHY_RESETN,
   input logic                  rcv_ack,
   input logic                  data_rcvd,
   input eth_rx_pkg::byte_cnt_t rcv_size,
   input logic                  phy_dv_detected
);

   // Acknowledge wins over a frame end in the same cycle
   ack_blocks_flag: assert property (
      @(posedge RX_CLK) disable iff (!ETH_PHY_RESETN)
      rcv_ack |=> !data_rcvd
   ) else $error("data_rcvd is high in the cycle after rcv_ack");

   // Activity flag only clears on reset
   dv_flag_sticky: assert property (
      @(posedge RX_CLK) disable iff (!ETH_PHY_RESETN)
      phy_dv_detected |=> phy_dv_detected
   ) else $error("phy_dv_detected fell without a reset");

   // Length stays frozen until the host acknowledges
   size_frozen: assert property (
      @(posedge RX_CLK) disable iff (!ETH_PHY_RESETN)
      data_rcvd |=> (!data_rcvd || $stable(rcv_size))
   ) else $error("rcv_size changed while data_rcvd was high");

endmodule

// File: dv/eth_rx_tb.sv
`timescale 1ns/100ps

module eth_rx_tb;
   import eth_rx_pkg::*;

   localparam mac_addr_t STATION_MAC = 48'h02_00_00_00_00_01;
   localparam int BUF_ADDR_W = 9;
   localparam int PAT_DEPTH = 1024;
   // Each test needs well under 200 cycles, room for 100 tests
   localparam int MAX_CYCLES = 200 * 100;
   // Ticks from RX_DV low to data_rcvd, one edge per stage plus the sampling edge
   localparam int ACCEPT_TICKS = 5;
   localparam int REJECT_WINDOW = 8;

   logic                  RX_CLK;
   logic                  ETH_PHY_RESETN;
   nibble_t               RX_DATA;
   logic                  RX_DV;
   logic                  rcv_ack;
   logic [BUF_ADDR_W-1:0] rd_addr;
   word_t                 rd_data;
   logic                  data_rcvd;
   byte_cnt_t             rcv_size;
   crc_t                  crc_value;
   logic                  phy_dv_detected;

   byte_t pat_mem [PAT_DEPTH];
   // Frame that the buffer must hold while data_rcvd is high
   byte_t held_frame [256];
   int    held_len;
   logic  pending;
   int    seed;
   int    cycle_cnt = 0;
   int    test_err;
   int    err_cnt;
   int    pass_cnt;
   int    fail_cnt;

   eth_rx_top #(.ETH_MAC_ADDR(STATION_MAC), .BUF_ADDR_W(BUF_ADDR_W)) uut (
      .RX_CLK (RX_CLK), .ETH_PHY_RESETN (ETH_PHY_RESETN),
      .RX_DATA (RX_DATA), .RX_DV (RX_DV), .rcv_ack (rcv_ack), .rd_addr (rd_addr),
      .rd_data (rd_data), .data_rcvd (data_rcvd), .rcv_size (rcv_size),
      .crc_value (crc_value), .phy_dv_detected (phy_dv_detected)
   );

   bind eth_rx_top eth_rx_chk u_chk (
      .RX_CLK (RX_CLK), .ETH_PHY_RESETN (ETH_PHY_RESETN), .rcv_ack (rcv_ack),
      .data_rcvd (data_rcvd), .rcv_size (rcv_size), .phy_dv_detected (phy_dv_detected)
   );

   initial begin
      RX_CLK = 1'b0;
      forever #10 RX_CLK = ~RX_CLK;
   end

   always @(posedge RX_CLK) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= MAX_CYCLES) begin
         $display("Run stopped, the tests did not finish within %0d cycles", MAX_CYCLES);
         $display("Testbench failed");
         $finish;
      end
   end

   // Inputs change 2 ns after the rising edge
   task automatic tick();
      @(posedge RX_CLK);
      #2;
   endtask

   task automatic send_nibble(input nibble_t nib);
      RX_DV = 1'b1;
      RX_DATA = nib;
      tick();
   endtask

   // Preamble, SFD, then each byte low nibble first
   task automatic send_frame(input int base, input int pre_cnt, input int len, input bit odd);
      for (int i = 0; i < pre_cnt; i++) begin
         send_nibble(4'h5);
      end
      send_nibble(4'hD);
      for (int i = 0; i < len; i++) begin
         send_nibble(pat_mem[base + i][3:0]);
         send_nibble(pat_mem[base + i][7:4]);
      end
      if (odd) begin
         send_nibble(4'hA);
      end
      RX_DV = 1'b0;
      RX_DATA = 4'h0;
   endtask

   // Reflected CRC-32 over the frame bytes, preset all ones, no final inversion
   function automatic crc_t frame_crc(input int base, input int len);
      crc_t c;
      crc_t r;
      c = 32'hFFFF_FFFF;
      for (int i = 0; i < len; i++) begin
         c = c ^ {24'h0, pat_mem[base + i]};
         for (int b = 0; b < 8; b++) begin
            c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
         end
      end
      // DUT register holds the same bits in reverse order
      for (int i = 0; i < 32; i++) begin
         r[i] = c[31 - i];
      end
      return r;
   endfunction

   task automatic compare_buffer();
      word_t word;
      for (int w = 0; w < (held_len + 3) / 4; w++) begin
         rd_addr = BUF_ADDR_W'(w);
         tick();
         word = rd_data;
         for (int lane = 0; lane < 4; lane++) begin
            if (4 * w + lane < held_len && word[8*lane +: 8] !== held_frame[4*w + lane]) begin
               $display("error at %0d ns: word %0d lane %0d is %h, expected %h", $time, w,
                        lane, word[8*lane +: 8], held_frame[4*w + lane]);
               test_err++;
            end
         end
      end
   endtask

   initial begin
      int ptr;
      int test_id;
      int pre_cnt;
      int accept;
      int ack;
      int odd;
      int len;
      int lat;
      int gap;
      crc_t exp_crc;
      ETH_PHY_RESETN = 1'b0;
      RX_DV = 1'b0;
      RX_DATA = 4'h0;
      rcv_ack = 1'b0;
      rd_addr = '0;
      seed = 32'h8203;
      pending = 1'b0;
      held_len = 0;
      err_cnt = 0;
      pass_cnt = 0;
      fail_cnt = 0;
      for (int i = 0; i < PAT_DEPTH; i++) begin
         pat_mem[i] = 8'h00;
      end
      $readmemh("dv/eth_rx_patterns.txt", pat_mem);
      repeat (2) @(posedge RX_CLK);
      #2;
      ETH_PHY_RESETN = 1'b1;
      if (data_rcvd !== 1'b0 || phy_dv_detected !== 1'b0 || rcv_size !== '0) begin
         $display("error at %0d ns: outputs not cleared by reset", $time);
         err_cnt++;
      end
      ptr = 0;
      while (pat_mem[ptr] != 8'h00) begin
         test_id = int'(pat_mem[ptr]);
         pre_cnt = int'(pat_mem[ptr + 1]);
         accept = int'(pat_mem[ptr + 2]);
         ack = int'(pat_mem[ptr + 3]);
         odd = int'(pat_mem[ptr + 4]);
         len = int'(pat_mem[ptr + 5]);
         ptr += 6;
         test_err = 0;
         send_frame(ptr, pre_cnt, len, odd != 0);
         if (accept != 0 && !pending) begin
            lat = 0;
            while (!data_rcvd && lat < 16) begin
               tick();
               lat++;
            end
            if (!data_rcvd) begin
               $display("test %0d: the frame was never flagged as received", test_id);
               test_err++;
            end else if (lat != ACCEPT_TICKS) begin
               $display("error at %0d ns: data_rcvd rose after %0d cycles, expected %0d",
                        $time, lat, ACCEPT_TICKS);
               test_err++;
            end
            if (int'(rcv_size) != len) begin
               $display("error at %0d ns: rcv_size is %0d, expected %0d", $time, rcv_size, len);
               test_err++;
            end
            pending = 1'b1;
            held_len = len;
            for (int i = 0; i < len; i++) begin
               held_frame[i] = pat_mem[ptr + i];
            end
         end else begin
            // Dropped frame leaves the flag as it was
            repeat (REJECT_WINDOW) begin
               tick();
               if (data_rcvd !== pending) begin
                  $display("error at %0d ns: data_rcvd is %b, expected %b", $time, data_rcvd,
                           pending);
                  test_err++;
               end
            end
         end
         // Status register follows every frame, kept or dropped
         exp_crc = frame_crc(ptr, len);
         if (crc_value !== exp_crc) begin
            $display("error at %0d ns: crc_value is %h, expected %h", $time, crc_value,
                     exp_crc);
            test_err++;
         end
         if (pending) begin
            compare_buffer();
         end
         if (phy_dv_detected !== 1'b1) begin
            $display("error at %0d ns: phy_dv_detected is low after a frame", $time);
            test_err++;
         end
         if (ack != 0) begin
            rcv_ack = 1'b1;
            tick();
            rcv_ack = 1'b0;
            pending = 1'b0;
            if (data_rcvd !== 1'b0) begin
               $display("error at %0d ns: data_rcvd still high after rcv_ack", $time);
               test_err++;
            end
         end
         gap = 12 + ($random(seed) & 7);
         repeat (gap) tick();
         $display("test %0d: %s", test_id, (test_err == 0) ? "ok" : "FAILED");
         if (test_err == 0) begin
            pass_cnt++;
         end else begin
            fail_cnt++;
         end
         err_cnt += test_err;
         ptr += len;
      end
      $display("%0d tests ok, %0d tests failing, %0d errors", pass_cnt, fail_cnt, err_cnt);
      if (fail_cnt == 0 && err_cnt == 0 && pass_cnt > 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

// File: dv/eth_rx_patterns.txt
// test, preamble nibbles, frame qualifies, ack after, odd tail nibble, byte count, bytes
// All fields hex, bytes include the FCS, a test number of 00 ends the list
// Unicast to the station address
01 0F 01 01 00 16 02 00 00 00 00 01 C1 CF F2 74 00 00 08 00 08 8A D9 C8 FF FF FF FF
// Broadcast
02 0F 01 01 00 16 FF FF FF FF FF FF FF 12 26 BE 00 00 08 00 08 8A D9 C8 FF FF FF FF
// Another station, FCS correct
03 0F 00 01 00 0D 31 32 33 34 35 36 37 38 39 26 39 F4 CB
// Unicast with byte 13 corrupted
04 0F 00 01 00 16 02 00 00 00 00 01 C1 CF F2 74 00 00 08 55 08 8A D9 C8 FF FF FF FF
// Unicast ending on a lone nibble
05 0F 00 01 01 16 02 00 00 00 00 01 C1 CF F2 74 00 00 08 00 08 8A D9 C8 FF FF FF FF
// Held without ack, then a good frame that must be lost
06 0F 01 00 00 17 02 00 00 00 00 01 C1 CF F2 74 00 00 08 00 08 8A D9 C8 00 FF FF FF FF
07 0F 01 01 00 16 FF FF FF FF FF FF FF 12 26 BE 00 00 08 00 08 8A D9 C8 FF FF FF FF
08 0F 01 01 00 1A FF FF FF FF FF FF FF 12 26 BE 00 00 08 00 08 8A D9 C8 00 00 00 00 FF FF FF FF
// Short preamble
09 07 01 01 00 19 02 00 00 00 00 01 C1 CF F2 74 00 00 08 00 08 8A D9 C8 00 00 00 FF FF FF FF
0A 07 01 01 00 16 FF FF FF FF FF FF FF 12 26 BE 00 00 08 00 08 8A D9 C8 FF FF FF FF
00

// File: verilog.f
logic/eth_rx_pkg.sv
logic/mii_nibble_assembler.sv
logic/eth_addr_filter.sv
logic/eth_crc_check.sv
logic/rx_frame_buffer.sv
logic/eth_rx_top.sv
dv/eth_rx_chk.sv
dv/eth_rx_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the MII receive testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module eth_rx_tb || exit 1

sim_out="$(./obj_dir/Veth_rx_tb 2>&1)"
echo "$sim_out"

echo "$sim_out" | grep -qx "Testbench passed" && echo "PASS" || { echo "FAIL"; exit 1; }
